//--- src/alu_macros.svh
// ALU width and opcode defines
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath width
`define ALU_WIDTH 32

// command bus width, enough for eight operations
`define ALU_CMD_WIDTH 3

// command encodings
`define ADD_OP  3'd0
`define SUB_OP  3'd1
`define XOR_OP  3'd2
`define SLT_OP  3'd3 // signed compare
`define AND_OP  3'd4
`define NAND_OP 3'd5
`define NOR_OP  3'd6
`define OR_OP   3'd7

`endif

//--- src/aluPkg.sv
// ALU shared types
`include "alu_macros.svh"

package aluPkg;

    // one datapath word
    typedef logic [`ALU_WIDTH-1:0] word_t;

    // command as seen on the external bus
    typedef enum logic [`ALU_CMD_WIDTH-1:0] {
        ALU_ADD  = `ADD_OP,
        ALU_SUB  = `SUB_OP,
        ALU_XOR  = `XOR_OP,
        ALU_SLT  = `SLT_OP,
        ALU_AND  = `AND_OP,
        ALU_NAND = `NAND_OP,
        ALU_NOR  = `NOR_OP,
        ALU_OR   = `OR_OP
    } aluOp_e;

    // functional unit whose word goes to the output
    typedef enum logic [2:0] {
        UNIT_ADDER = 3'd0,
        UNIT_XOR   = 3'd1,
        UNIT_SLT   = 3'd2,
        UNIT_NAND  = 3'd3, // also or, with both operands inverted
        UNIT_NOR   = 3'd4  // also and, with both operands inverted
    } unitSel_e;

endpackage

//--- src/aluResultsIf.sv
// ALU unit results bundle
`timescale 1ns/1ps

interface aluResultsIf;

    // adder outputs
    aluPkg::word_t sumWord;
    logic          adderCarry;    // final carry of the ripple chain
    logic          adderOverflow; // signed overflow

    // bitwise and compare units
    aluPkg::word_t xorWord;
    aluPkg::word_t nandWord;
    aluPkg::word_t norWord;
    aluPkg::word_t sltWord;       // only bit 0 can be set

    // datapath side
    modport producer (
        output sumWord,
        output adderCarry,
        output adderOverflow,
        output xorWord,
        output nandWord,
        output norWord,
        output sltWord
    );

    // output select side
    modport consumer (
        input sumWord,
        input adderCarry,
        input adderOverflow,
        input xorWord,
        input nandWord,
        input norWord,
        input sltWord
    );

endinterface

//--- src/aluDecoder.sv
// ALU command decoder
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluDecoder (
    input  logic [`ALU_CMD_WIDTH-1:0] command,
    output aluPkg::unitSel_e          unitSel,
    output logic                      invertA,
    output logic                      invertB
);

    aluPkg::aluOp_e op;

    assign op = aluPkg::aluOp_e'(command);

    // and/or reuse nor/nand by inverting both inputs (de morgan)
    always_comb begin
        case (op)
            aluPkg::ALU_ADD: begin
                unitSel = aluPkg::UNIT_ADDER;
                invertA = 1'b0;
                invertB = 1'b0;
            end
            aluPkg::ALU_SUB: begin
                unitSel = aluPkg::UNIT_ADDER;
                invertA = 1'b0;
                invertB = 1'b1; // a + ~b + 1
            end
            aluPkg::ALU_XOR: begin
                unitSel = aluPkg::UNIT_XOR;
                invertA = 1'b0;
                invertB = 1'b0;
            end
            aluPkg::ALU_SLT: begin
                unitSel = aluPkg::UNIT_SLT;
                invertA = 1'b0;
                invertB = 1'b1; // compare via subtraction
            end
            aluPkg::ALU_AND: begin
                unitSel = aluPkg::UNIT_NOR;
                invertA = 1'b1;
                invertB = 1'b1;
            end
            aluPkg::ALU_NAND: begin
                unitSel = aluPkg::UNIT_NAND;
                invertA = 1'b0;
                invertB = 1'b0;
            end
            aluPkg::ALU_NOR: begin
                unitSel = aluPkg::UNIT_NOR;
                invertA = 1'b0;
                invertB = 1'b0;
            end
            aluPkg::ALU_OR: begin
                unitSel = aluPkg::UNIT_NAND;
                invertA = 1'b1;
                invertB = 1'b1;
            end
            default: begin
                unitSel = aluPkg::UNIT_ADDER;
                invertA = 1'b0;
                invertB = 1'b0;
            end
        endcase
    end

endmodule

//--- src/rippleCarryAdder.sv
// Ripple carry adder
`timescale 1ns/1ps
`include "alu_macros.svh"

module rippleCarryAdder (
    input  aluPkg::word_t a,
    input  aluPkg::word_t b,
    input  logic          carryIn,  // 1 for subtract and compare
    output aluPkg::word_t sum,
    output logic          carryOut,
    output logic          overflow  // signed overflow
);

    logic msbCarryIn; // carry entering the sign bit
    logic lastCarry;

    // one full adder per bit, carry rippling upward from bit 0
    always_comb begin
        logic carry;
        logic halfSum;
        carry      = carryIn;
        msbCarryIn = 1'b0;
        sum        = '0;
        for (int i = 0; i < `ALU_WIDTH; i++) begin
            if (i == `ALU_WIDTH - 1) begin
                msbCarryIn = carry;
            end
            halfSum = a[i] ^ b[i];
            sum[i]  = halfSum ^ carry;
            // generate, or propagate the incoming carry
            carry   = (a[i] & b[i]) | (halfSum & carry);
        end
        lastCarry = carry;
    end

    assign carryOut = lastCarry;

    // sign bit disagrees with the true result when these differ
    assign overflow = msbCarryIn ^ lastCarry;

endmodule

//--- src/aluDatapath.sv
// ALU functional units
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluDatapath (
    input  aluPkg::word_t    operandA,
    input  aluPkg::word_t    operandB,
    input  logic             invertA,
    input  logic             invertB,
    aluResultsIf.producer    results
);

    // operands after optional inversion
    aluPkg::word_t inA;
    aluPkg::word_t inB;

    // adder outputs before they go onto the bundle
    aluPkg::word_t sum;
    logic          carry;
    logic          ovf;

    logic          lessThan;

    assign inA = invertA ? ~operandA : operandA;
    assign inB = invertB ? ~operandB : operandB;

    // carry in follows invertB so that ~b + 1 forms -b
    rippleCarryAdder u_adder (
        .a        (inA),
        .b        (inB),
        .carryIn  (invertB),
        .sum      (sum),
        .carryOut (carry),
        .overflow (ovf)
    );

    assign results.sumWord       = sum;
    assign results.adderCarry    = carry;
    assign results.adderOverflow = ovf;

    // bitwise units share the conditioned operands
    assign results.xorWord  = inA ^ inB;
    assign results.nandWord = ~(inA & inB); // or when both inputs inverted
    assign results.norWord  = ~(inA | inB); // and when both inputs inverted

    // a - b negative, corrected by overflow
    assign lessThan = sum[`ALU_WIDTH-1] ^ ovf;

    assign results.sltWord = {{(`ALU_WIDTH-1){1'b0}}, lessThan};

endmodule

//--- src/resultStage.sv
// ALU output select and register
`timescale 1ns/1ps

module resultStage (
    input  logic              clk,
    input  logic              rstN,
    input  aluPkg::unitSel_e  unitSel,
    aluResultsIf.consumer     results,
    output aluPkg::word_t     result,
    output logic              carryout,
    output logic              zero,
    output logic              overflow
);

    aluPkg::word_t selWord;
    logic          selCarry;
    logic          selOverflow;
    logic          selZero;

    // pick the unit word; flags only survive for the adder
    always_comb begin
        selCarry    = 1'b0;
        selOverflow = 1'b0;
        case (unitSel)
            aluPkg::UNIT_ADDER: begin
                selWord     = results.sumWord;
                selCarry    = results.adderCarry;
                selOverflow = results.adderOverflow;
            end
            aluPkg::UNIT_XOR: begin
                selWord = results.xorWord;
            end
            aluPkg::UNIT_SLT: begin
                selWord = results.sltWord;
            end
            aluPkg::UNIT_NAND: begin
                selWord = results.nandWord;
            end
            aluPkg::UNIT_NOR: begin
                selWord = results.norWord;
            end
            default: begin
                selWord = results.sumWord; // unused select codes
            end
        endcase
    end

    assign selZero = (selWord == '0);

    // one cycle of latency from operands to outputs
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result   <= '0;
            carryout <= 1'b0;
            zero     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            result   <= selWord;
            carryout <= selCarry;
            zero     <= selZero;
            overflow <= selOverflow;
        end
    end

endmodule

//--- src/aluTop.sv
// 32-bit ALU top level
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluTop (
    input  logic                      clk,
    input  logic                      rstN,
    input  aluPkg::word_t             operandA,
    input  aluPkg::word_t             operandB,
    input  logic [`ALU_CMD_WIDTH-1:0] command,
    output aluPkg::word_t             result,
    output logic                      carryout,
    output logic                      zero,
    output logic                      overflow
);

    // decoder controls
    aluPkg::unitSel_e unitSel;
    logic             invertA;
    logic             invertB;

    // unit outputs, datapath to output stage
    aluResultsIf resultsBus ();

    aluDecoder u_aluDecoder (
        .command (command),
        .unitSel (unitSel),
        .invertA (invertA),
        .invertB (invertB)
    );

    aluDatapath u_aluDatapath (
        .operandA (operandA),
        .operandB (operandB),
        .invertA  (invertA),
        .invertB  (invertB),
        .results  (resultsBus.producer)
    );

    // registered outputs, valid the cycle after sampling
    resultStage u_resultStage (
        .clk      (clk),
        .rstN     (rstN),
        .unitSel  (unitSel),
        .results  (resultsBus.consumer),
        .result   (result),
        .carryout (carryout),
        .zero     (zero),
        .overflow (overflow)
    );

endmodule

//--- testbench/aluTb.sv
// ALU self-checking testbench
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluTb;

    localparam int RESET_CYCLES   = 10;
    // add 225, sub 225, slt 245, bitwise 5 x 100, zero flag 80
    localparam int TOTAL_OPS      = 225 + 225 + 245 + 500 + 80;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_OPS + 100;

    // everything the DUT reports for one operation
    typedef struct packed {
        aluPkg::word_t result;
        logic          carryout;
        logic          zero;
        logic          overflow;
    } aluOut_t;

    logic                      clk;
    logic                      rstN;
    aluPkg::word_t             operandA;
    aluPkg::word_t             operandB;
    logic [`ALU_CMD_WIDTH-1:0] command;
    aluPkg::word_t             result;
    logic                      carryout;
    logic                      zero;
    logic                      overflow;

    // operations applied but not yet checked
    string          nameQ[$];
    aluPkg::word_t  aQ[$];
    aluPkg::word_t  bQ[$];
    aluPkg::aluOp_e opQ[$];

    int appliedCount = 0;
    int checkedCount = 0;
    int errorCount   = 0;
    int testsOk      = 0;
    int testsBad     = 0;
    int cycleCount   = 0;
    int testErrBase  = 0;
    int testOpsBase  = 0;

    aluPkg::word_t corners [5] = '{32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff,
                                   32'h8000_0000, 32'h0000_0001};

    aluTop u_aluTop (
        .clk      (clk),
        .rstN     (rstN),
        .operandA (operandA),
        .operandB (operandB),
        .command  (command),
        .result   (result),
        .carryout (carryout),
        .zero     (zero),
        .overflow (overflow)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // expected outputs straight from the arithmetic rules
    function automatic aluOut_t computeExpected(input aluPkg::word_t a, input aluPkg::word_t b,
                                                input aluPkg::aluOp_e op);
        aluOut_t            e;
        logic [`ALU_WIDTH:0] wide; // sum with carry on top
        e    = '0;
        wide = '0;
        case (op)
            aluPkg::ALU_ADD: begin
                wide       = {1'b0, a} + {1'b0, b};
                e.result   = wide[`ALU_WIDTH-1:0];
                e.carryout = wide[`ALU_WIDTH];
                // same-sign inputs giving a result of the other sign
                e.overflow = (a[`ALU_WIDTH-1] == b[`ALU_WIDTH-1]) &&
                             (e.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
            end
            aluPkg::ALU_SUB: begin
                wide       = {1'b0, a} + {1'b0, ~b} + (`ALU_WIDTH+1)'(1);
                e.result   = wide[`ALU_WIDTH-1:0];
                e.carryout = wide[`ALU_WIDTH];
                e.overflow = (a[`ALU_WIDTH-1] != b[`ALU_WIDTH-1]) &&
                             (e.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
            end
            aluPkg::ALU_SLT:  e.result = ($signed(a) < $signed(b)) ? aluPkg::word_t'(1) : '0;
            aluPkg::ALU_XOR:  e.result = a ^ b;
            aluPkg::ALU_AND:  e.result = a & b;
            aluPkg::ALU_NAND: e.result = ~(a & b);
            aluPkg::ALU_NOR:  e.result = ~(a | b);
            aluPkg::ALU_OR:   e.result = a | b;
            default:          e.result = '0;
        endcase
        e.zero = (e.result == '0);
        return e;
    endfunction

    // drive one operation a little after the edge and remember it
    task automatic applyOp(input string name, input aluPkg::aluOp_e op,
                           input aluPkg::word_t a, input aluPkg::word_t b);
        @(posedge clk);
        #1;
        operandA = a;
        operandB = b;
        command  = op;
        nameQ.push_back(name);
        aQ.push_back(a);
        bQ.push_back(b);
        opQ.push_back(op);
        appliedCount++;
    endtask

    task automatic randomSweep(input string name, input aluPkg::aluOp_e op, input int count);
        aluPkg::word_t a;
        aluPkg::word_t b;
        for (int i = 0; i < count; i++) begin
            a = $urandom;
            b = $urandom;
            applyOp(name, op, a, b);
        end
    endtask

    // every pairing of the corner words including equal pairs
    task automatic cornerSweep(input string name, input aluPkg::aluOp_e op);
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                applyOp(name, op, corners[i], corners[j]);
            end
        end
    endtask

    task automatic checkResetOutputs(input string phase);
        assert (result == '0 && !carryout && !zero && !overflow) else begin
            $write("Mismatch test=reset (%s) expected result=00000000 c=0 z=0 v=0", phase);
            $display(" actual result=%h c=%b z=%b v=%b", result, carryout, zero, overflow);
            errorCount++;
        end
    endtask

    task automatic startTest();
        testErrBase = errorCount;
        testOpsBase = appliedCount;
    endtask

    // wait for the pipeline to drain, then report the test
    task automatic finishTest(input string name);
        int errs;
        while (checkedCount != appliedCount) @(posedge clk);
        errs = errorCount - testErrBase;
        if (errs == 0) begin
            testsOk++;
            $display("test %s: %0d operations, ok", name, appliedCount - testOpsBase);
        end else begin
            testsBad++;
            $display("test %s: %0d operations, %0d errors", name,
                     appliedCount - testOpsBase, errs);
        end
    endtask

    // outputs for the op sampled at a rising edge are read at the next falling edge
    initial begin : compareOutputs
        string          tName;
        aluPkg::word_t  a;
        aluPkg::word_t  b;
        aluPkg::aluOp_e op;
        aluOut_t        expd;
        aluOut_t        got;
        logic           haveOp;
        forever begin
            @(posedge clk);
            haveOp = (opQ.size() > 0);
            if (haveOp) begin
                tName = nameQ.pop_front();
                a     = aQ.pop_front();
                b     = bQ.pop_front();
                op    = opQ.pop_front();
            end
            @(negedge clk);
            if (haveOp) begin
                expd = computeExpected(a, b, op);
                got  = {result, carryout, zero, overflow};
                assert (got == expd) else begin
                    $write("Mismatch test=%s op=%s a=%h b=%h", tName, op.name(), a, b);
                    $write(" expected result=%h c=%b z=%b v=%b", expd.result, expd.carryout,
                           expd.zero, expd.overflow);
                    $display(" actual result=%h c=%b z=%b v=%b", got.result, got.carryout,
                             got.zero, got.overflow);
                    errorCount++;
                end
                assert (zero == (result == '0)) else begin
                    $display("zero flag is %b while result is %h in test %s", zero, result, tName);
                    errorCount++;
                end
                checkedCount++;
            end
        end
    end

    initial begin : stimulus
        aluPkg::word_t  a;
        aluPkg::word_t  b;
        aluPkg::aluOp_e op;
        rstN     = 1'b0;
        operandA = '0;
        operandB = '0;
        command  = `ADD_OP;
        void'($urandom(32'h1ddb_2424));

        startTest();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            @(negedge clk);
            checkResetOutputs("held");
        end
        @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkResetOutputs("released"); // no edge has sampled an op yet
        finishTest("reset");

        startTest();
        randomSweep("add", aluPkg::ALU_ADD, 200);
        cornerSweep("add", aluPkg::ALU_ADD);
        finishTest("add");

        startTest();
        randomSweep("sub", aluPkg::ALU_SUB, 200);
        cornerSweep("sub", aluPkg::ALU_SUB); // includes 80000000 - 1
        finishTest("sub");

        startTest();
        randomSweep("slt", aluPkg::ALU_SLT, 200);
        cornerSweep("slt", aluPkg::ALU_SLT);
        for (int i = 0; i < 20; i++) begin
            a = $urandom;
            applyOp("slt", aluPkg::ALU_SLT, a, a ^ 32'h8000_0000); // sign bit only
        end
        finishTest("slt");

        startTest();
        randomSweep("bitwise", aluPkg::ALU_XOR, 100);
        randomSweep("bitwise", aluPkg::ALU_AND, 100);
        randomSweep("bitwise", aluPkg::ALU_NAND, 100);
        randomSweep("bitwise", aluPkg::ALU_NOR, 100);
        randomSweep("bitwise", aluPkg::ALU_OR, 100);
        finishTest("bitwise");

        startTest();
        for (int i = 0; i < 10; i++) begin
            a = $urandom;
            b = $urandom;
            applyOp("zero", aluPkg::ALU_XOR, a, a);
            applyOp("zero", aluPkg::ALU_SUB, a, a);
            applyOp("zero", aluPkg::ALU_AND, a, ~a);
            applyOp("zero", aluPkg::ALU_NOR, 32'hffff_ffff, b);
        end
        // new command every cycle
        op = aluPkg::ALU_ADD;
        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            b = (i % 3 == 0) ? a : $urandom;
            applyOp("zero", op, a, b);
            op = op.next();
        end
        finishTest("zero");

        $display("tests: %0d ok, %0d with errors; %0d operations checked, %0d errors",
                 testsOk, testsBad, checkedCount, errorCount);
        if (testsBad == 0 && errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/aluPkg.sv
src/aluResultsIf.sv
src/aluDecoder.sv
src/rippleCarryAdder.sv
src/aluDatapath.sv
src/resultStage.sv
src/aluTop.sv
testbench/aluTb.sv

//--- run.sh
#!/bin/sh
# build and run the ALU simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aluTb -f verilog.f -o aluSim

# keep the simulator's own exit status out of the decision
./obj_dir/aluSim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
